// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f list.f --top-module uopExpanderTb -Mdir obj_dir
	./obj_dir/VuopExpanderTb

clean:
	rm -rf obj_dir

// ==== design/regListWalker.sv ====
`timescale 1ns/1ps
`default_nettype none

module regListWalker (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  uopPkg::instrWord instr,
	input  logic             listLoad,
	output uopPkg::regIdx    curReg,
	output uopPkg::regCount  listCount,
	output logic             lastReg
);
	import uopPkg::*;

	regList remaining; // Registers still to transfer
	regList workList;  // List seen this cycle
	regList nextList;

	// First cycle takes the list straight from the instruction
	assign workList = listLoad ? instr[15:0] : remaining;

	// Lowest set bit wins, scan from the top down
	always_comb begin
		curReg = '0;
		for (int i = 15; i >= 0; i--) begin
			if (workList[i]) begin
				curReg = regIdx'(i);
			end
		end
	end

	assign listCount = regCount'($countones(workList));
	assign lastReg   = (listCount == regCount'(1)); // One register left

	// Drop the register issued this cycle
	always_comb begin
		nextList         = workList;
		nextList[curReg] = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			remaining <= '0;
		end else if (!stall) begin
			remaining <= nextList;
		end
	end

endmodule

`default_nettype wire

// ==== design/uopBuilder.sv ====
`timescale 1ns/1ps
`default_nettype none

module uopBuilder (
	input  uopPkg::instrWord instr,
	input  uopPkg::seqState  state,
	input  uopPkg::uopClass  cls,
	input  uopPkg::regIdx    curReg,
	input  uopPkg::regCount  listCount,
	output uopPkg::instrWord uopInstr,
	output logic             instrMux,
	output logic             noFlagUpdate,
	output logic             lsmForward,
	output logic             keepV,
	output logic             prevRsr,
	output uopPkg::rzSelect  regFileRz
);
	import uopPkg::*;

	logic [11:0] lsmBytes; // N words in bytes
	logic [11:0] startImm; // First transfer offset from Rn
	logic        startAdd; // U bit of first transfer
	regCount     fullCount;
	logic [7:0]  wbBytes;  // Base adjustment for writeback

	assign lsmBytes  = 12'(listCount) * 12'(cWordBytes);
	assign fullCount = regCount'($countones(instr[15:0]));
	assign wbBytes   = 8'(fullCount) * 8'(cWordBytes); // At most 64, fits imm8 unrotated

	// Addressing mode from P and U bits
	always_comb begin
		case (instr[24:23])
			2'b00: begin // DA, lowest address is Rn - (N-1)*4
				startImm = lsmBytes - 12'(cWordBytes);
				startAdd = 1'b0;
			end
			2'b01: begin // IA
				startImm = '0;
				startAdd = 1'b1;
			end
			2'b10: begin // DB
				startImm = lsmBytes;
				startAdd = 1'b0;
			end
			default: begin // IB
				startImm = 12'(cWordBytes);
				startAdd = 1'b1;
			end
		endcase
	end

	always_comb begin
		uopInstr     = instr; // Pass-through unless overridden
		noFlagUpdate = 1'b0;
		lsmForward   = 1'b0;
		keepV        = 1'b0;
		prevRsr      = 1'b0;
		regFileRz    = cRzNone;
		case (state)
			stReady: begin
				case (cls)
					clsRsr: begin // MOV Rz, Rm <shift> Rs
						uopInstr     = {instr[31:25], 4'b1101, 1'b0, 4'b0000, cRzReg, instr[11:0]};
						noFlagUpdate = 1'b1;
						regFileRz    = cRzMovFirst;
					end
					clsMla: begin // MUL Rz, Rm, Rs with A and S cleared
						uopInstr  = {instr[31:24], 1'b0, instr[22], 1'b0, 1'b0,
							cRzReg, 4'b0000, instr[11:0]};
						keepV     = 1'b1;
						regFileRz = cRzMovFirst;
					end
					clsBl: begin // SUB lr, pc, #4
						uopInstr = {instr[31:28], 3'b001, 4'b0010, 1'b0, cPcReg, cLinkReg,
							12'(cWordBytes)};
					end
					clsLdm, clsStm: begin // First single transfer off Rn, pre-indexed
						uopInstr     = {instr[31:28], 3'b010, 1'b1, startAdd, 1'b0, 1'b0, instr[20],
							instr[19:16], curReg, startImm};
						noFlagUpdate = 1'b1;
					end
					default: ;
				endcase
			end
			stRsr: begin // Original op reading Rz unshifted
				uopInstr  = {instr[31:12], 8'b0, cRzReg};
				prevRsr   = 1'b1;
				regFileRz = cRzReadB;
			end
			stMla: begin // ADD Rd, Rz, Rn with original S
				uopInstr  = {instr[31:28], 3'b000, 4'b0100, instr[20], cRzReg, instr[19:16],
					8'b0, instr[15:12]};
				regFileRz = cRzReadA;
			end
			stBl: begin
				uopInstr = {instr[31:25], 1'b0, instr[23:0]}; // Link bit off
			end
			stLdm, stStm: begin // Next word above forwarded address in Rz
				uopInstr     = {instr[31:28], 3'b010, 1'b1, 1'b1, 1'b0, 1'b0, instr[20],
					cRzReg, curReg, 12'(cWordBytes)};
				noFlagUpdate = 1'b1;
				lsmForward   = 1'b1;
				regFileRz    = cRzReadA;
			end
			stWriteback: begin // ADD or SUB Rn, Rn, #N*4
				uopInstr     = {instr[31:28], 3'b001, 1'b0, instr[23], ~instr[23], 1'b0, 1'b0,
					instr[19:16], instr[19:16], 4'b0000, wbBytes};
				noFlagUpdate = 1'b1;
			end
			default: ;
		endcase
	end

	// Any expansion step replaces the fetched word
	assign instrMux = !((state == stReady) && (cls == clsPass));

endmodule

`default_nettype wire

// ==== design/uopDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module uopDecode (
	input  uopPkg::instrWord instr,
	output uopPkg::uopClass  cls
);
	import uopPkg::*;

	logic isRsr;
	logic isBxFamily;
	logic isMla;
	logic isBl;
	logic isLsm;

	// BX and BLX share the reg-shift bit pattern, keep them out
	assign isBxFamily = (instr[27:6] == {8'b0001_0010, 12'hfff, 2'b00});

	// Data processing, register shift amount
	assign isRsr = (instr[27:25] == 3'b000) && !instr[7] && instr[4] && !isBxFamily;

	// Accumulate bit set, multiply signature in 7:4
	assign isMla = (instr[27:21] == 7'h01) && (instr[7:4] == 4'b1001);

	assign isBl = (instr[27:24] == 4'b1011); // Link bit set

	// Block transfer with at least one register
	assign isLsm = (instr[27:25] == 3'b100) && (instr[15:0] != '0);

	always_comb begin
		if (isRsr) begin
			cls = clsRsr;
		end else if (isMla) begin
			cls = clsMla;
		end else if (isBl) begin
			cls = clsBl;
		end else if (isLsm) begin
			cls = instr[20] ? clsLdm : clsStm; // L bit picks load
		end else begin
			cls = clsPass;
		end
	end

endmodule

`default_nettype wire

// ==== design/uopExpander.sv ====
`timescale 1ns/1ps
`default_nettype none

module uopExpander (
	input  logic             clk,
	input  logic             reset,
	input  uopPkg::instrWord instr,
	input  logic             stall,
	output uopPkg::instrWord uopInstr,
	output logic             instrMux,
	output logic             noFlagUpdate,
	output logic             uopStall,
	output logic             lsmForward,
	output logic             keepV,
	output logic             prevRsr,
	output uopPkg::rzSelect  regFileRz
);
	import uopPkg::*;

	uopClass cls;
	seqState state;
	logic    listLoad;
	regIdx   curReg;
	regCount listCount;
	logic    lastReg;

	uopDecode decode0 (
		.instr (instr),
		.cls   (cls)
	);

	regListWalker walker0 (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.instr     (instr),
		.listLoad  (listLoad),
		.curReg    (curReg),
		.listCount (listCount),
		.lastReg   (lastReg)
	);

	uopSequencer sequencer0 (
		.clk      (clk),
		.reset    (reset),
		.stall    (stall),
		.instr    (instr),
		.cls      (cls),
		.lastReg  (lastReg),
		.state    (state),
		.listLoad (listLoad),
		.uopStall (uopStall)
	);

	uopBuilder builder0 (
		.instr        (instr),
		.state        (state),
		.cls          (cls),
		.curReg       (curReg),
		.listCount    (listCount),
		.uopInstr     (uopInstr),
		.instrMux     (instrMux),
		.noFlagUpdate (noFlagUpdate),
		.lsmForward   (lsmForward),
		.keepV        (keepV),
		.prevRsr      (prevRsr),
		.regFileRz    (regFileRz)
	);

endmodule

`default_nettype wire

// ==== design/uopPkg.sv ====
`default_nettype none

package uopPkg;

	typedef logic [31:0] instrWord; // Instruction or micro-op word
	typedef logic [3:0]  regIdx;    // Register number
	typedef logic [15:0] regList;   // LDM/STM register bitmap
	typedef logic [4:0]  regCount;  // Set bits in a list, 0..16
	typedef logic [3:0]  rzSelect;  // {RA1 mux, WA3, RA2, RA1} routing to Rz

	// Expansion class of the fetched word
	typedef enum logic [2:0] {
		clsPass,
		clsRsr,
		clsMla,
		clsBl,
		clsLdm,
		clsStm
	} uopClass;

	// Sequencer position inside an expansion
	typedef enum logic [2:0] {
		stReady,
		stRsr,     // Second half of reg-shifted-reg op
		stMla,     // Accumulate add
		stBl,      // Plain branch after link setup
		stLdm,     // Remaining single loads
		stStm,     // Remaining single stores
		stWriteback
	} seqState;

	// Register codes
	localparam regIdx cRzReg   = 4'd15; // Code 15 is Rz when routed by regFileRz
	localparam regIdx cPcReg   = 4'd15;
	localparam regIdx cLinkReg = 4'd14;

	localparam int cWordBytes = 4; // Word transfer stride

	// Scratch register routing
	localparam rzSelect cRzNone     = 4'b0000;
	localparam rzSelect cRzMovFirst = 4'b1100; // Write port to Rz, RA1 mux steered
	localparam rzSelect cRzReadA    = 4'b0001; // Read port 1 from Rz
	localparam rzSelect cRzReadB    = 4'b0010; // Read port 2 from Rz

endpackage

`default_nettype wire

// ==== design/uopSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module uopSequencer (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  uopPkg::instrWord instr,
	input  uopPkg::uopClass  cls,
	input  logic             lastReg,
	output uopPkg::seqState  state,
	output logic             listLoad,
	output logic             uopStall
);
	import uopPkg::*;

	seqState nextState;
	logic    writeBack;
	seqState lsmEnd; // Where a block transfer goes after its last register

	assign writeBack = instr[21]; // W bit
	assign lsmEnd    = writeBack ? stWriteback : stReady;

	always_comb begin
		nextState = stReady;
		case (state)
			stReady: begin
				case (cls)
					clsRsr:  nextState = stRsr;
					clsMla:  nextState = stMla;
					clsBl:   nextState = stBl;
					clsLdm:  nextState = lastReg ? lsmEnd : stLdm; // Single register skips loop
					clsStm:  nextState = lastReg ? lsmEnd : stStm;
					default: nextState = stReady;
				endcase
			end
			stLdm: nextState = lastReg ? lsmEnd : stLdm;
			stStm: nextState = lastReg ? lsmEnd : stStm;
			default: nextState = stReady; // Two-step ops and writeback finish here
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stReady;
		end else if (!stall) begin
			state <= nextState; // Stall holds the sequence in place
		end
	end

	assign listLoad = (state == stReady);
	assign uopStall = (nextState != stReady); // Fetch holds until the last micro-op

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tests
design/uopPkg.sv
design/uopDecode.sv
design/regListWalker.sv
design/uopSequencer.sv
design/uopBuilder.sv
design/uopExpander.sv
tests/uopExpanderTb.sv

// ==== tests/uopVectors.svh ====
`ifndef UOP_VECTORS_SVH
`define UOP_VECTORS_SVH

// Columns: word (cond replaced at run time), class, micro-op count, stall mid-sequence
// A count of 0 marks a block transfer whose register list is drawn at random
localparam int cVecCount = 19;

localparam instrWord vecWord [cVecCount] = '{
	32'he082_1003, 32'he12f_ff13, 32'hea00_0004, 32'he890_0000, // Pass-through
	32'he081_0312, 32'he1b0_4675,                               // RSR
	32'he021_4392, 32'he035_6798,                               // MLA and MLAS
	32'heb00_0010, 32'hebff_fff0,                               // BL
	32'he890_000e, 32'he8b0_000e, 32'he92d_4070, 32'he812_8001, // LDM/STM modes
	32'he983_0080, 32'he935_0202,
	32'he8b0_0000, 32'he900_0000, 32'he9b0_0000                 // Random lists
};

localparam uopClass vecCls [cVecCount] = '{
	clsPass, clsPass, clsPass, clsPass,
	clsRsr, clsRsr,
	clsMla, clsMla,
	clsBl, clsBl,
	clsLdm, clsLdm, clsStm, clsLdm,
	clsStm, clsLdm,
	clsLdm, clsStm, clsLdm
};

localparam int vecLen [cVecCount] = '{
	1, 1, 1, 1,
	2, 2,
	2, 2,
	2, 2,
	3, 4, 5, 2,
	1, 3,
	0, 0, 0
};

localparam bit vecStall [cVecCount] = '{
	0, 0, 0, 0, 0, 1, 0, 1, 0, 1, 0, 0, 1, 0, 0, 1, 0, 0, 1
};

`endif

// ==== tests/uopExpanderTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uopExpanderTb;
	import uopPkg::*;

	`include "uopVectors.svh"

	logic     clk;
	logic     reset;
	instrWord instr;
	logic     stall;
	instrWord uopInstr;
	logic     instrMux, noFlagUpdate, uopStall, lsmForward, keepV, prevRsr;
	rzSelect  regFileRz;
	int       cycles;
	int       cycleLimit;

	uopExpander dut0 (
		.clk(clk), .reset(reset), .instr(instr), .stall(stall),
		.uopInstr(uopInstr), .instrMux(instrMux), .noFlagUpdate(noFlagUpdate),
		.uopStall(uopStall), .lsmForward(lsmForward), .keepV(keepV),
		.prevRsr(prevRsr), .regFileRz(regFileRz)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit) begin
			$display("Run did not finish within %0d cycles", cycleLimit);
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic checkWord(string name, instrWord got, instrWord exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic checkRz(string name, rzSelect got, rzSelect exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "routing mismatch");
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "flag mismatch");
		end
	endtask

	// Register number of the k-th set bit counted from r0
	function automatic regIdx nthReg(regList lst, int k);
		int seen;
		seen = 0;
		for (int r = 0; r < 16; r++) begin
			if (lst[r]) begin
				if (seen == k) return regIdx'(r);
				seen++;
			end
		end
		return '0;
	endfunction

	// Expected micro-op k of word w
	function automatic instrWord refWord(instrWord w, uopClass c, int k);
		int         n;
		logic       up;
		logic [11:0] off;
		n  = $countones(w[15:0]);
		up = w[23];
		case (c)
			clsRsr: return (k == 0) ? {w[31:25], 4'b1101, 1'b0, 4'h0, cRzReg, w[11:0]}
				: {w[31:12], 8'h00, cRzReg};
			clsMla: return (k == 0) ? {w[31:28], 7'b0000000, 1'b0, cRzReg, 4'h0, w[11:0]}
				: {w[31:28], 3'b000, 4'b0100, w[20], cRzReg, w[19:16], 8'h00, w[15:12]};
			clsBl: return (k == 0) ? {w[31:28], 3'b001, 4'b0010, 1'b0, cPcReg, cLinkReg, 12'd4}
				: {w[31:25], 1'b0, w[23:0]};
			clsLdm, clsStm: begin
				if (k == n) // Base writeback by N words, ADD when U set and SUB otherwise
					return {w[31:28], 3'b001, up ? 4'b0100 : 4'b0010, 1'b0, w[19:16], w[19:16],
						4'h0, 8'(n * 4)};
				if (k > 0)
					return {w[31:28], 3'b010, 4'b1100, w[20], cRzReg, nthReg(w[15:0], k), 12'd4};
				if (w[24]) off = up ? 12'd4 : 12'(n * 4);
				else off = up ? 12'd0 : 12'((n - 1) * 4);
				return {w[31:28], 3'b010, 1'b1, up, 2'b00, w[20], w[19:16], nthReg(w[15:0], 0), off};
			end
			default: return w;
		endcase
	endfunction

	function automatic rzSelect refRz(uopClass c, int k, int n);
		if (c == clsRsr) return (k == 0) ? cRzMovFirst : cRzReadB;
		if (c == clsMla) return (k == 0) ? cRzMovFirst : cRzReadA;
		if ((c == clsLdm || c == clsStm) && k > 0 && k < n) return cRzReadA;
		return cRzNone;
	endfunction

	task automatic checkStep(instrWord w, uopClass c, int k, int len);
		int  n;
		logic lsm;
		n   = $countones(w[15:0]);
		lsm = (c == clsLdm) || (c == clsStm);
		checkWord("uopInstr", uopInstr, refWord(w, c, k));
		checkRz("regFileRz", regFileRz, refRz(c, k, n));
		checkFlag("uopStall", uopStall, k != len - 1);
		checkFlag("instrMux", instrMux, c != clsPass);
		checkFlag("noFlagUpdate", noFlagUpdate, (c == clsRsr && k == 0) || lsm);
		checkFlag("lsmForward", lsmForward, lsm && k > 0 && k < n);
		checkFlag("keepV", keepV, c == clsMla && k == 0);
		checkFlag("prevRsr", prevRsr, c == clsRsr && k == 1);
	endtask

	initial begin
		instrWord w;
		int       len;
		void'($urandom(32'hfa10_49ac));
		cycles     = 0;
		cycleLimit = (cVecCount * 17 + 12) * 4 + 8; // Worst case lengths plus stall holds
		reset      = 1'b1;
		stall      = 1'b0;
		instr      = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < cVecCount; i++) begin
			w   = vecWord[i];
			len = vecLen[i];
			w[31:28] = 4'($urandom_range(14, 0)); // Any condition but NV
			if (vecCls[i] == clsLdm || vecCls[i] == clsStm) begin
				w[19:16] = 4'($urandom_range(15, 0));
				if (len == 0) begin
					w[15:0] = 16'($urandom_range(65535, 1));
					len     = $countones(w[15:0]) + (w[21] ? 1 : 0);
				end
			end
			@(negedge clk);
			instr = w;
			for (int k = 0; k < len; k++) begin
				if (k > 0) @(negedge clk);
				if (vecStall[i] && k == 1) begin // Freeze two edges mid-sequence
					stall = 1'b1;
					repeat (2) begin
						#10 checkStep(w, vecCls[i], k, len);
						@(negedge clk);
					end
					stall = 1'b0;
				end
				#10 checkStep(w, vecCls[i], k, len);
			end
		end
		@(negedge clk);
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire
